/* ex_stage.sv */
`timescale 1ns/1ns
`include "rv_pipe_macros.svh"

module ex_stage import rv_pipe_pkg::*; (
    input  id_ex_data_t ex_data,
    input  id_ex_ctrl_t ex_ctrl,
    output ex_out_t     ex_out,
    output logic        branch_taken,
    output xlen_t       branch_target
);

    localparam int shamt_w = $clog2(`XLEN);

    xlen_t              src_a;
    xlen_t              src_b;
    xlen_t              alu_y;
    logic [shamt_w-1:0] shamt;
    logic               cmp_eq;
    logic               cmp_lt;

    assign src_a = ex_ctrl.alu_src[1] ? '0 : ex_data.read_data1;
    assign src_b = ex_ctrl.alu_src[0] ? ex_data.imm_ext : ex_data.read_data2;
    assign shamt = src_b[shamt_w-1:0];

    always_comb begin
        case (ex_ctrl.alu_ctrl)
            alu_add:    alu_y = src_a + src_b;
            alu_sub:    alu_y = src_a - src_b;
            alu_and:    alu_y = src_a & src_b;
            alu_or:     alu_y = src_a | src_b;
            alu_xor:    alu_y = src_a ^ src_b;
            alu_slt:    alu_y = ($signed(src_a) < $signed(src_b)) ? xlen_t'(1) : '0;
            alu_sltu:   alu_y = (src_a < src_b) ? xlen_t'(1) : '0;
            alu_sll:    alu_y = src_a << shamt;
            alu_srl:    alu_y = src_a >> shamt;
            alu_sra:    alu_y = xlen_t'($signed(src_a) >>> shamt);
            alu_pass_b: alu_y = src_b;
            default:    alu_y = '0;
        endcase
    end

    // Branches compare the register operands, never the immediate
    assign cmp_eq = (ex_data.read_data1 == ex_data.read_data2);
    assign cmp_lt = ($signed(ex_data.read_data1) < $signed(ex_data.read_data2));

    always_comb begin
        case (ex_ctrl.branch_jump)
            bj_beq:  branch_taken = cmp_eq;
            bj_bne:  branch_taken = !cmp_eq;
            bj_blt:  branch_taken = cmp_lt;
            bj_bge:  branch_taken = !cmp_lt;
            bj_jal:  branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    assign branch_target = ex_data.pc + ex_data.imm_ext;

    always_comb begin
        ex_out            = '0;
        ex_out.reg_write  = ex_ctrl.reg_write;
        ex_out.mem_write  = ex_ctrl.mem_write;
        ex_out.rd         = ex_data.rd;
        ex_out.store_data = ex_data.read_data2;
        if (ex_ctrl.result_src == res_pc_plus4) begin
            ex_out.result = ex_data.pc_plus4;  // Link address for JAL
        end else begin
            ex_out.result = alu_y;  // For SW this is the store address
        end
    end

endmodule

/* id_stage.sv */
`timescale 1ns/1ns
`include "rv_pipe_macros.svh"

module id_stage import rv_pipe_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        instr_valid,
    input  xlen_t       instr,
    input  xlen_t       pc,
    input  logic        wb_en,
    input  reg_idx_t    wb_rd,
    input  xlen_t       wb_data,
    output id_ex_data_t id_data,
    output id_ex_ctrl_t id_ctrl
);

    logic [6:0] opcode;
    funct3_t    funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       funct7_5;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      imm_ext;
    xlen_t      read_data1;
    xlen_t      read_data2;

    // OP and OP_IMM share the funct3 map, only OP may select sub
    function automatic alu_ctrl_e decode_alu(input funct3_t f3, input logic alt,
                                             input logic reg_op);
        alu_ctrl_e op;
        op = alu_add;
        case (f3)
            `F3_ADD_SUB: op = (reg_op && alt) ? alu_sub : alu_add;
            `F3_SLL:     op = alu_sll;
            `F3_SLT:     op = alu_slt;
            `F3_SLTU:    op = alu_sltu;
            `F3_XOR:     op = alu_xor;
            `F3_SRL_SRA: op = alt ? alu_sra : alu_srl;
            `F3_OR:      op = alu_or;
            `F3_AND:     op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign funct7_5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    reg_file u_rf (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (wb_en),
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (read_data1),
        .rdata2 (read_data2)
    );

    always_comb begin
        id_ctrl = '0;  // Anything not matched below leaves a bubble
        imm_ext = '0;
        case (opcode)
            `OPC_OP: begin
                id_ctrl.reg_write = 1'b1;
                id_ctrl.alu_ctrl  = decode_alu(funct3, funct7_5, 1'b1);
            end
            `OPC_OP_IMM: begin
                imm_ext           = imm_i;
                id_ctrl.reg_write = 1'b1;
                id_ctrl.alu_src   = 2'b01;
                id_ctrl.alu_ctrl  = decode_alu(funct3, funct7_5, 1'b0);
            end
            `OPC_LUI: begin
                imm_ext           = imm_u;
                id_ctrl.reg_write = 1'b1;
                id_ctrl.alu_src   = 2'b11;  // Zero plus the upper immediate
                id_ctrl.alu_ctrl  = alu_add;
            end
            `OPC_STORE: begin
                imm_ext = imm_s;
                if (funct3 == `F3_SW) begin
                    id_ctrl.mem_write = 1'b1;
                    id_ctrl.alu_src   = 2'b01;
                end
            end
            `OPC_BRANCH: begin
                imm_ext = imm_b;
                case (funct3)
                    `F3_BEQ: id_ctrl.branch_jump = bj_beq;
                    `F3_BNE: id_ctrl.branch_jump = bj_bne;
                    `F3_BLT: id_ctrl.branch_jump = bj_blt;
                    `F3_BGE: id_ctrl.branch_jump = bj_bge;
                    default: id_ctrl.branch_jump = bj_none;
                endcase
            end
            `OPC_JAL: begin
                imm_ext             = imm_j;
                id_ctrl.reg_write   = 1'b1;
                id_ctrl.result_src  = res_pc_plus4;
                id_ctrl.branch_jump = bj_jal;
            end
            default: begin
                imm_ext = '0;
            end
        endcase
        if (!instr_valid) begin
            id_ctrl = '0;
        end
    end

    always_comb begin
        id_data            = '0;
        id_data.pc         = pc;
        id_data.pc_plus4   = pc + xlen_t'(4);
        id_data.rs1        = rs1;
        id_data.rs2        = rs2;
        id_data.rd         = rd;
        id_data.imm_ext    = imm_ext;
        id_data.read_data1 = read_data1;
        id_data.read_data2 = read_data2;
        id_data.funct3     = funct3;
    end

endmodule

/* pipereg_id_ex.sv */
`timescale 1ns/1ns

module pipereg_id_ex import rv_pipe_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clr,
    input  id_ex_data_t data_in,
    input  id_ex_ctrl_t ctrl_in,
    output id_ex_data_t data_out,
    output id_ex_ctrl_t ctrl_out
);

    // The data word always follows decode, even for a squashed slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
        end else begin
            data_out <= data_in;
        end
    end

    // Flush replaces the control word with a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_out <= '0;
        end else if (clr) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= ctrl_in;
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ns
`include "rv_pipe_macros.svh"

module reg_file import rv_pipe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     we,
    input  reg_idx_t waddr,
    input  xlen_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [1:`NUM_REGS-1];  // x0 has no storage

    logic wr_active;

    assign wr_active = we && (waddr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[waddr] <= wdata;
        end
    end

    // A write in flight is forwarded so decode sees it in the same cycle
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else if (wr_active && (raddr1 == waddr)) begin
            rdata1 = wdata;
        end else begin
            rdata1 = regs[raddr1];
        end

        if (raddr2 == '0) begin
            rdata2 = '0;
        end else if (wr_active && (raddr2 == waddr)) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* rv_id_ex_top.f */
+incdir+.
rv_pipe_pkg.sv
reg_file.sv
id_stage.sv
pipereg_id_ex.sv
ex_stage.sv
rv_id_ex_top.sv
tb_rv_id_ex_assertions.sv
tb_rv_id_ex_top.sv

/* rv_id_ex_top.sv */
`timescale 1ns/1ns

module rv_id_ex_top import rv_pipe_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  xlen_t    instr,
    input  xlen_t    pc,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_data,
    output ex_out_t  ex_out,
    output logic     branch_taken,
    output xlen_t    branch_target
);

    id_ex_data_t id_data;
    id_ex_ctrl_t id_ctrl;
    id_ex_data_t ex_data;
    id_ex_ctrl_t ex_ctrl;

    id_stage u_id (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .id_data     (id_data),
        .id_ctrl     (id_ctrl)
    );

    // A taken branch in execute squashes the instruction now in decode
    pipereg_id_ex u_id_ex (
        .clk      (clk),
        .arst_n   (arst_n),
        .clr      (branch_taken),
        .data_in  (id_data),
        .ctrl_in  (id_ctrl),
        .data_out (ex_data),
        .ctrl_out (ex_ctrl)
    );

    ex_stage u_ex (
        .ex_data       (ex_data),
        .ex_ctrl       (ex_ctrl),
        .ex_out        (ex_out),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

/* rv_pipe_macros.svh */
`ifndef RV_PIPE_MACROS_SVH
`define RV_PIPE_MACROS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// RV32I major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// ALU funct3 values, shared by OP and OP_IMM
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// Branch and store funct3 values
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_SW       3'b010

`endif

/* rv_pipe_pkg.sv */
`include "rv_pipe_macros.svh"

package rv_pipe_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [2:0]             funct3_t;

    // Bit 0 picks the immediate as operand b, bit 1 forces operand a to zero
    typedef logic [1:0]             alu_src_t;

    // The zero value of every enum must stay the bubble encoding
    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_ctrl_e;

    typedef enum logic [2:0] {
        bj_none,
        bj_beq,
        bj_bne,
        bj_blt,
        bj_bge,
        bj_jal
    } branch_jump_e;

    typedef enum logic [1:0] {
        res_alu,
        res_pc_plus4
    } result_src_e;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    pc_plus4;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm_ext;
        xlen_t    read_data1;
        xlen_t    read_data2;
        funct3_t  funct3;
    } id_ex_data_t;

    typedef struct packed {
        logic         reg_write;
        result_src_e  result_src;
        logic         mem_write;
        alu_ctrl_e    alu_ctrl;
        branch_jump_e branch_jump;
        alu_src_t     alu_src;
    } id_ex_ctrl_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_write;
        reg_idx_t rd;
        xlen_t    result;
        xlen_t    store_data;
    } ex_out_t;

endpackage

/* tb_rv_id_ex_assertions.sv */
`timescale 1ns/1ns

module tb_rv_id_ex_assertions import rv_pipe_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input ex_out_t ex_out,
    input logic    branch_taken,
    input xlen_t   branch_target
);

    int fail_count = 0;  // Summed into the testbench error count

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!ex_out.reg_write && !ex_out.mem_write && !branch_taken))
    else begin
        fail_count++;
        $error("Write enable or branch_taken high while in reset");
    end

    // The slot behind a taken branch must be a bubble
    a_flush_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        branch_taken |=> (!ex_out.reg_write && !ex_out.mem_write && !branch_taken))
    else begin
        fail_count++;
        $error("Instruction after a taken branch was not squashed");
    end

    a_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({ex_out, branch_taken, branch_target}))
    else begin
        fail_count++;
        $error("Unknown value on the execute outputs");
    end

endmodule

bind rv_id_ex_top tb_rv_id_ex_assertions u_assert (
    .clk           (clk),
    .arst_n        (arst_n),
    .ex_out        (ex_out),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
);

/* tb_rv_id_ex_top.sv */
`timescale 1ns/1ns
`include "rv_pipe_macros.svh"

module tb_rv_id_ex_top import rv_pipe_pkg::*; ();

    localparam int num_instr = 49;  // Instructions plus write-port loads over all tests

    logic     clk = 1'b0;
    logic     arst_n;
    logic     instr_valid;
    xlen_t    instr;
    xlen_t    pc;
    logic     wb_en;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    ex_out_t  ex_out;
    logic     branch_taken;
    xlen_t    branch_target;
    int       checks = 0;
    int       errors = 0;

    rv_id_ex_top u_dut (.*);

    always #10 clk = ~clk;

    function automatic xlen_t enc_r(input logic alt, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input funct3_t f3, input reg_idx_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input funct3_t f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic xlen_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    // Reference ALU following the RV32I instruction definitions
    function automatic xlen_t ref_alu(input funct3_t f3, input logic alt, input xlen_t a,
                                      input xlen_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(input funct3_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    task automatic check_val(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_quiet();
        check_val("ex_out.reg_write", 0, ex_out.reg_write);
        check_val("ex_out.mem_write", 0, ex_out.mem_write);
        check_val("branch_taken", 0, branch_taken);
    endtask

    task automatic check_alu(input xlen_t exp, input reg_idx_t rd);
        check_val("ex_out.result", exp, ex_out.result);
        check_val("ex_out.rd", xlen_t'(rd), xlen_t'(ex_out.rd));
        check_val("ex_out.reg_write", 1, ex_out.reg_write);
    endtask

    task automatic write_reg(input reg_idx_t rd, input xlen_t data);
        @(posedge clk);
        wb_en   <= 1'b1;
        wb_rd   <= rd;
        wb_data <= data;
        @(posedge clk);
        wb_en <= 1'b0;
    endtask

    // Result of the instruction is at the outputs when this returns
    task automatic present(input xlen_t ins, input xlen_t p);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        pc          <= p;
        @(posedge clk);
        instr_valid <= 1'b0;
        wb_en       <= 1'b0;
        @(negedge clk);
    endtask

    // A branch followed back to back by an ADD that a taken branch squashes
    task automatic branch_pair(input xlen_t ins, input xlen_t p, input logic exp_taken,
                               input xlen_t exp_target);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        pc          <= p;
        @(posedge clk);
        instr <= enc_r(1'b0, 5'd2, 5'd1, `F3_ADD_SUB, 5'd6);
        pc    <= p + 32'd4;
        @(negedge clk);
        check_val("branch_taken", exp_taken, branch_taken);
        check_val("branch_target", exp_target, branch_target);
        if (ins[6:0] == `OPC_JAL) begin
            check_alu(p + 32'd4, ins[11:7]);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_val("ex_out.reg_write", !exp_taken, ex_out.reg_write);
    endtask

    task automatic test_reset_bubbles();
        int e0;
        e0 = errors;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= enc_r(1'b0, 5'd2, 5'd1, `F3_ADD_SUB, 5'd3);
        repeat (14) @(posedge clk);
        @(negedge clk);
        check_quiet();
        @(posedge clk);
        arst_n      <= 1'b1;
        instr_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_quiet();
        $display("Test reset_bubbles finished with %0d errors", errors - e0);
    endtask

    task automatic test_reg_reg();
        funct3_t f3s [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
        logic    alts [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        xlen_t   a;
        xlen_t   b;
        int      e0;
        e0 = errors;
        a  = $urandom;
        b  = $urandom;
        write_reg(5'd1, a);
        write_reg(5'd2, b);
        for (int i = 0; i < 10; i++) begin
            present(enc_r(alts[i], 5'd2, 5'd1, f3s[i], 5'd3), 32'h40 + 4 * i);
            check_alu(ref_alu(f3s[i], alts[i], a, b), 5'd3);
        end
        present(enc_r(1'b0, 5'd2, 5'd1, `F3_ADD_SUB, 5'd0), 32'h80);
        check_val("ex_out.rd", 0, ex_out.rd);
        write_reg(5'd0, $urandom | 32'h1);
        present(enc_r(1'b0, 5'd2, 5'd0, `F3_ADD_SUB, 5'd4), 32'h84);  // x0 still reads zero
        check_alu(b, 5'd4);
        $display("Test reg_reg finished with %0d errors", errors - e0);
    endtask

    task automatic test_immediates();
        logic [11:0] imms [4] = '{12'hFFB, 12'hFFF, 12'hF00, 12'h407};
        funct3_t     f3s [4] = '{`F3_ADD_SUB, `F3_SLT, `F3_XOR, `F3_SRL_SRA};
        xlen_t       a;
        int          e0;
        e0 = errors;
        a  = $urandom | 32'h8000_0000;  // Negative so SRAI shifts in ones
        write_reg(5'd1, a);
        for (int i = 0; i < 4; i++) begin
            present(enc_i(imms[i], 5'd1, f3s[i], 5'd5), 32'h100 + 4 * i);
            check_alu(ref_alu(f3s[i], (f3s[i] == 3'd5) && imms[i][10], a,
                              {{20{imms[i][11]}}, imms[i]}), 5'd5);
        end
        present({20'hFFFFF, 5'd5, `OPC_LUI}, 32'h110);
        check_alu(32'hFFFFF000, 5'd5);
        $display("Test immediates finished with %0d errors", errors - e0);
    endtask

    task automatic test_store();
        xlen_t base;
        xlen_t data;
        int    e0;
        e0   = errors;
        base = $urandom;
        data = $urandom;
        write_reg(5'd1, base);
        write_reg(5'd2, data);
        present({7'h7F, 5'd2, 5'd1, `F3_SW, 5'h14, `OPC_STORE}, 32'h200);  // Offset -12
        check_val("ex_out.result", base - 32'd12, ex_out.result);
        check_val("ex_out.store_data", data, ex_out.store_data);
        check_val("ex_out.mem_write", 1, ex_out.mem_write);
        check_val("ex_out.reg_write", 0, ex_out.reg_write);
        $display("Test store finished with %0d errors", errors - e0);
    endtask

    task automatic test_branches();
        reg_idx_t rs1s [8] = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd3, 5'd1, 5'd1, 5'd3};
        reg_idx_t rs2s [8] = '{5'd2, 5'd3, 5'd3, 5'd2, 5'd1, 5'd3, 5'd3, 5'd1};
        funct3_t  f3s [8] = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5};
        xlen_t    pos;
        xlen_t    neg;
        xlen_t    p;
        int       off;
        int       e0;
        e0  = errors;
        pos = $urandom & 32'h7FFF_FFFF;
        neg = $urandom | 32'h8000_0000;
        write_reg(5'd1, pos);
        write_reg(5'd2, pos);
        write_reg(5'd3, neg);
        for (int i = 0; i < 8; i++) begin
            off = i * 8 - 20;
            p   = 32'h300 + 32 * i;
            branch_pair(enc_b(13'(off), rs2s[i], rs1s[i], f3s[i]), p,
                        ref_taken(f3s[i], (rs1s[i] == 5'd3) ? neg : pos,
                                  (rs2s[i] == 5'd3) ? neg : pos), p + xlen_t'(off));
        end
        // JAL x4 with offset -1024
        branch_pair({1'b1, 10'h200, 1'b1, 8'hFF, 5'd4, `OPC_JAL}, 32'h800, 1'b1, 32'h400);
        $display("Test branches finished with %0d errors", errors - e0);
    endtask

    task automatic test_bypass();
        xlen_t old_v;
        int    e0;
        e0    = errors;
        old_v = $urandom;
        write_reg(5'd7, old_v);
        @(posedge clk);
        wb_en       <= 1'b1;
        wb_rd       <= 5'd7;
        wb_data     <= ~old_v;
        instr_valid <= 1'b1;
        instr       <= enc_r(1'b0, 5'd0, 5'd7, `F3_ADD_SUB, 5'd8);
        pc          <= 32'h900;
        @(posedge clk);
        wb_en       <= 1'b0;
        instr_valid <= 1'b0;
        @(negedge clk);
        check_alu(~old_v, 5'd8);
        $display("Test bypass finished with %0d errors", errors - e0);
    endtask

    initial begin
        void'($urandom(12386));
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        wb_en       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        test_reset_bubbles();
        test_reg_reg();
        test_immediates();
        test_store();
        test_branches();
        test_bypass();
        errors += u_dut.u_assert.fail_count;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(num_instr * 20 * 4);
        $display("Watchdog expired after %0d ns, the tests did not finish", num_instr * 80);
        $display("Checks failed");
        $finish;
    end

endmodule
